// ==== hw/la_decode_defines.svh ====
`ifndef LA_DECODE_DEFINES_SVH
`define LA_DECODE_DEFINES_SVH

// privilege and counter opcodes, inst[31:10]
`define ERTN_OPCODE      22'b0000011001001000001110
`define RDCNTID_OPCODE   22'b0000000000000000011000
`define RDCNTVHW_OPCODE  22'b0000000000000000011001
`define TLBSRCH_OPCODE   22'b0000011001001000001010
`define TLBRD_OPCODE     22'b0000011001001000001011
`define TLBWR_OPCODE     22'b0000011001001000001100
`define TLBFILL_OPCODE   22'b0000011001001000001101
`define INVTLB_OPCODE    17'b00000110010010011      // inst[31:15]

// 2R-I12 opcodes, inst[31:22]
`define ADDIW_OPCODE     10'b0000001010
`define SLTI_OPCODE      10'b0000001000
`define SLTUI_OPCODE     10'b0000001001
`define ANDI_OPCODE      10'b0000001101
`define ORI_OPCODE       10'b0000001110
`define XORI_OPCODE      10'b0000001111

`define ALU_NOP          8'h00
`define ALU_ADDW         8'h01
`define ALU_SLT          8'h02
`define ALU_SLTU         8'h03
`define ALU_AND          8'h04
`define ALU_OR           8'h05
`define ALU_XOR          8'h06
`define ALU_ERTN         8'h10
`define ALU_RDCNTID      8'h11
`define ALU_RDCNTVLW     8'h12
`define ALU_RDCNTVHW     8'h13
`define ALU_TLBSRCH      8'h14
`define ALU_TLBRD        8'h15
`define ALU_TLBWR        8'h16
`define ALU_TLBFILL      8'h17
`define ALU_INVTLB       8'h18

`define ALU_SEL_NOP      3'b000
`define ALU_SEL_ARITH    3'b001
`define ALU_SEL_LOGIC    3'b010
`define ALU_SEL_CSR      3'b110

`define EXCEPTION_ADEF   7'h08
`define EXCEPTION_PIF    7'h03
`define EXCEPTION_INE    7'h0d

`define CSR_TID          14'h040

`define IQ_DEPTH         4
`define DQ_CREDITS       2

`endif

// ==== hw/la_decode_pkg.sv ====
`default_nettype none

package la_decode_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [7:0]  alu_op_t;
    typedef logic [2:0]  alu_sel_t;
    typedef logic [13:0] csr_addr_t;
    typedef logic [6:0]  exc_cause_t;

    typedef struct packed {
        addr_t pc;
        inst_t inst;
        logic  fault;       // fetch side fault
    } fetch_pkt_t;

    typedef struct packed {
        addr_t       pc;
        inst_t       inst;
        logic        inst_valid;
        logic        reg_write_en;
        reg_idx_t    reg_write_addr;
        logic        reg1_read_en;
        reg_idx_t    reg1_read_addr;
        logic        reg2_read_en;
        reg_idx_t    reg2_read_addr;
        alu_op_t     aluop;
        alu_sel_t    alusel;
        logic [31:0] imm;
        logic        is_privilege;
        logic        is_cnt;
        logic        csr_read_en;
        logic        csr_write_en;
        csr_addr_t   csr_addr;
        reg_idx_t    invtlb_op;
    } uop_t;

    typedef struct packed {
        logic [2:0] is_exception;   // {decoder, fetch, pc}
        exc_cause_t pc_cause;
        exc_cause_t fetch_cause;
        exc_cause_t dec_cause;
    } exc_t;

    typedef struct packed {
        uop_t uop;
        exc_t exc;
    } dec_out_t;

endpackage

`default_nettype wire

// ==== hw/inst_queue.sv ====
`default_nettype none
`include "la_decode_defines.svh"

module inst_queue
    import la_decode_pkg::*;
(
    input  wire        clk,
    input  wire        rst_n,
    input  wire        push,
    input  wire        fetch_pkt_t push_pkt,
    input  wire        pop,
    output logic       head_valid,
    output fetch_pkt_t head_pkt,
    output logic       credit
);

    localparam int PTR_W = (`IQ_DEPTH > 1) ? $clog2(`IQ_DEPTH) : 1;
    localparam int CNT_W = $clog2(`IQ_DEPTH + 1);

    fetch_pkt_t       mem [`IQ_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        ptr_next = (p == PTR_W'(`IQ_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign do_pop     = pop && head_valid;
    assign head_valid = (count != '0);
    assign head_pkt   = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_pkt;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            credit <= do_pop;   // one slot freed, back to fetch
        end
    end

endmodule

`default_nettype wire

// ==== hw/dec_priv_cnt.sv ====
`default_nettype none
`include "la_decode_defines.svh"

module dec_priv_cnt
    import la_decode_pkg::*;
(
    input  wire   inst_t inst,
    output logic  hit,
    output uop_t  uop
);

    logic [21:0] opcode;
    logic [16:0] opcode_inv;
    reg_idx_t    rk;
    reg_idx_t    rj;
    reg_idx_t    rd;

    assign opcode     = inst[31:10];
    assign opcode_inv = inst[31:15];
    assign rk         = inst[14:10];
    assign rj         = inst[9:5];
    assign rd         = inst[4:0];

    always_comb begin
        uop          = '0;
        uop.csr_addr = `CSR_TID;
        hit          = 1'b1;
        if (opcode_inv == `INVTLB_OPCODE) begin
            uop.is_privilege   = 1'b1;
            uop.aluop          = `ALU_INVTLB;
            uop.alusel         = `ALU_SEL_CSR;
            uop.reg1_read_en   = 1'b1;
            uop.reg1_read_addr = rj;
            uop.reg2_read_en   = 1'b1;
            uop.reg2_read_addr = rk;
            uop.invtlb_op      = rd;    // op lives in rd field
        end else begin
            case (opcode)
                `ERTN_OPCODE: begin
                    uop.is_privilege = 1'b1;
                    uop.aluop        = `ALU_ERTN;
                end
                `RDCNTID_OPCODE: begin
                    uop.is_cnt       = 1'b1;
                    uop.reg_write_en = 1'b1;
                    uop.alusel       = `ALU_SEL_CSR;
                    if (rj != 5'b0) begin
                        uop.aluop          = `ALU_RDCNTID;
                        uop.reg_write_addr = rj;
                        uop.csr_read_en    = 1'b1;
                    end else begin
                        uop.aluop          = `ALU_RDCNTVLW;
                        uop.reg_write_addr = rd;
                    end
                end
                `RDCNTVHW_OPCODE: begin
                    uop.is_cnt         = 1'b1;
                    uop.reg_write_en   = 1'b1;
                    uop.reg_write_addr = rd;
                    uop.aluop          = `ALU_RDCNTVHW;
                    uop.alusel         = `ALU_SEL_CSR;
                end
                `TLBSRCH_OPCODE,
                `TLBRD_OPCODE,
                `TLBWR_OPCODE,
                `TLBFILL_OPCODE: begin
                    uop.is_privilege = 1'b1;
                    uop.alusel       = `ALU_SEL_CSR;
                    case (opcode[1:0])  // low bits tell the tlb ops apart
                        2'b10:   uop.aluop = `ALU_TLBSRCH;
                        2'b11:   uop.aluop = `ALU_TLBRD;
                        2'b00:   uop.aluop = `ALU_TLBWR;
                        default: uop.aluop = `ALU_TLBFILL;
                    endcase
                end
                default: hit = 1'b0;
            endcase
        end
        uop.inst_valid = hit;
    end

endmodule

`default_nettype wire

// ==== hw/dec_alu_i12.sv ====
`default_nettype none
`include "la_decode_defines.svh"

module dec_alu_i12
    import la_decode_pkg::*;
(
    input  wire   inst_t inst,
    output logic  hit,
    output uop_t  uop
);

    logic [9:0]  opcode;
    logic [11:0] imm12;
    logic        sext;

    assign opcode = inst[31:22];
    assign imm12  = inst[21:10];

    always_comb begin
        uop  = '0;
        hit  = 1'b1;
        sext = 1'b0;
        case (opcode)
            `ADDIW_OPCODE: begin
                uop.aluop  = `ALU_ADDW;
                uop.alusel = `ALU_SEL_ARITH;
                sext       = 1'b1;
            end
            `SLTI_OPCODE: begin
                uop.aluop  = `ALU_SLT;
                uop.alusel = `ALU_SEL_ARITH;
                sext       = 1'b1;
            end
            `SLTUI_OPCODE: begin
                uop.aluop  = `ALU_SLTU;
                uop.alusel = `ALU_SEL_ARITH;
                sext       = 1'b1;      // still sign extended, compared unsigned
            end
            `ANDI_OPCODE: begin
                uop.aluop  = `ALU_AND;
                uop.alusel = `ALU_SEL_LOGIC;
            end
            `ORI_OPCODE: begin
                uop.aluop  = `ALU_OR;
                uop.alusel = `ALU_SEL_LOGIC;
            end
            `XORI_OPCODE: begin
                uop.aluop  = `ALU_XOR;
                uop.alusel = `ALU_SEL_LOGIC;
            end
            default: hit = 1'b0;
        endcase
        if (hit) begin
            uop.inst_valid     = 1'b1;
            uop.reg1_read_en   = 1'b1;
            uop.reg1_read_addr = inst[9:5];
            uop.reg_write_en   = 1'b1;
            uop.reg_write_addr = inst[4:0];
            uop.imm            = sext ? {{20{imm12[11]}}, imm12} : {20'b0, imm12};
        end
    end

endmodule

`default_nettype wire

// ==== hw/decode_stage.sv ====
`default_nettype none
`include "la_decode_defines.svh"

module decode_stage
    import la_decode_pkg::*;
(
    input  wire        clk,
    input  wire        rst_n,
    input  wire        iq_valid,
    input  wire        fetch_pkt_t iq_head,
    output logic       iq_pop,
    input  wire        dec_credit,
    output logic       dec_valid,
    output dec_out_t   dec_out
);

    localparam int CRD_W = $clog2(`DQ_CREDITS + 1);

    logic             priv_hit;
    uop_t             priv_uop;
    logic             alu_hit;
    uop_t             alu_uop;
    uop_t             uop;
    exc_t             exc;
    logic             issue;
    logic [CRD_W-1:0] credit_cnt;

    dec_priv_cnt u_dec_priv_cnt (
        .inst (iq_head.inst),
        .hit  (priv_hit),
        .uop  (priv_uop)
    );

    dec_alu_i12 u_dec_alu_i12 (
        .inst (iq_head.inst),
        .hit  (alu_hit),
        .uop  (alu_uop)
    );

    // opcode sets are disjoint, order only matters for the miss case
    always_comb begin
        if (priv_hit) begin
            uop = priv_uop;
        end else if (alu_hit) begin
            uop = alu_uop;
        end else begin
            uop = '0;
        end
        uop.pc   = iq_head.pc;
        uop.inst = iq_head.inst;
    end

    always_comb begin
        exc.is_exception = {~(priv_hit | alu_hit), iq_head.fault, iq_head.pc[1:0] != 2'b00};
        exc.pc_cause     = `EXCEPTION_ADEF;
        exc.fetch_cause  = `EXCEPTION_PIF;
        exc.dec_cause    = `EXCEPTION_INE;
    end

    assign issue  = iq_valid && (credit_cnt != '0);
    assign iq_pop = issue;

    always_ff @(posedge clk) begin
        if (issue) begin
            dec_out.uop <= uop;
            dec_out.exc <= exc;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec_valid  <= 1'b0;
            credit_cnt <= CRD_W'(`DQ_CREDITS);
        end else begin
            dec_valid <= issue;
            case ({issue, dec_credit})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;     // none, or both cancel
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/la_decode_top.sv ====
`default_nettype none

module la_decode_top
    import la_decode_pkg::*;
(
    input  wire        clk,
    input  wire        rst_n,
    input  wire        fe_valid,
    input  wire        fetch_pkt_t fe_pkt,
    output logic       fe_credit,
    output logic       dec_valid,
    output dec_out_t   dec_out,
    input  wire        dec_credit
);

    logic       iq_valid;
    fetch_pkt_t iq_head;
    logic       iq_pop;

    inst_queue u_inst_queue (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (fe_valid),
        .push_pkt   (fe_pkt),
        .pop        (iq_pop),
        .head_valid (iq_valid),
        .head_pkt   (iq_head),
        .credit     (fe_credit)
    );

    decode_stage u_decode_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .iq_valid   (iq_valid),
        .iq_head    (iq_head),
        .iq_pop     (iq_pop),
        .dec_credit (dec_credit),
        .dec_valid  (dec_valid),
        .dec_out    (dec_out)
    );

endmodule

`default_nettype wire

// ==== tests/tb_la_decode.sv ====
`default_nettype none
`include "la_decode_defines.svh"

module tb_la_decode
    import la_decode_pkg::*;
();

    logic       clk;
    logic       rst_n;
    logic       fe_valid;
    fetch_pkt_t fe_pkt;
    logic       fe_credit;
    logic       dec_valid;
    dec_out_t   dec_out;
    logic       dec_credit;

    fetch_pkt_t vec_in[$];
    dec_out_t   vec_exp[$];
    int         be_due[$];      // cycles at which the back end returns a credit

    int seed;
    int errors;
    int checks;
    int tests;
    int failed_tests;
    int test_err;
    int nvec;
    bit loaded;
    int cycle;
    int sent;
    int rcvd;
    int fe_cred;
    int fe_pulses;
    int be_returned;
    int last_due;
    int due;
    int drain;
    int sent_cycle;
    int max_out;

    la_decode_top u_la_decode_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .fe_valid   (fe_valid),
        .fe_pkt     (fe_pkt),
        .fe_credit  (fe_credit),
        .dec_valid  (dec_valid),
        .dec_out    (dec_out),
        .dec_credit (dec_credit)
    );

    always #2 clk = ~clk;

    task automatic check_uop(input int idx, input uop_t got, input uop_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: dec_out.uop vector %0d got %h expected %h", idx, got, exp);
        end
    endtask

    task automatic check_exc(input int idx, input exc_t got, input exc_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: dec_out.exc vector %0d got %h expected %h", idx, got, exp);
        end
    endtask

    task automatic check_credit(input string name, input int got, input int lo, input int hi);
        checks++;
        if (got < lo || got > hi) begin
            errors++;
            $display("error: %s got %h expected %h to %h", name, got, lo, hi);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("error: dec_valid latency got %h expected %h", got, exp);
        end
    endtask

    task automatic report_test(input string name);
        tests++;
        if (errors != test_err) begin
            failed_tests++;
            $display("test %s: FAILED", name);
        end else begin
            $display("test %s: ok", name);
        end
        test_err = errors;
    endtask

    task automatic load_vectors();
        int         fd;
        int         n;
        string      line;
        addr_t      pc;
        inst_t      inst;
        logic       fault;
        logic [7:0] flags;
        reg_idx_t   wa;
        reg_idx_t   r1a;
        reg_idx_t   r2a;
        alu_op_t    aluop;
        alu_sel_t   alusel;
        logic [31:0] imm;
        csr_addr_t  csr;
        reg_idx_t   iop;
        logic [2:0] exc_bits;
        fetch_pkt_t pkt;
        dec_out_t   exp;
        fd = $fopen("tests/la_decode_vectors.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("the vector file tests/la_decode_vectors.txt could not be opened");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() < 8 || line[0] == "#") begin
                continue;   // blank or comment
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h", pc, inst, fault,
                        flags, wa, r1a, r2a, aluop, alusel, imm, csr, iop, exc_bits);
            if (n != 13) begin
                errors++;
                $display("a vector line could not be parsed: %s", line);
                continue;
            end
            pkt.pc                 = pc;
            pkt.inst               = inst;
            pkt.fault              = fault;
            exp                    = '0;
            exp.uop.pc             = pc;
            exp.uop.inst           = inst;
            exp.uop.inst_valid     = flags[7];
            exp.uop.reg_write_en   = flags[6];
            exp.uop.reg1_read_en   = flags[5];
            exp.uop.reg2_read_en   = flags[4];
            exp.uop.is_privilege   = flags[3];
            exp.uop.is_cnt         = flags[2];
            exp.uop.csr_read_en    = flags[1];
            exp.uop.csr_write_en   = flags[0];
            exp.uop.reg_write_addr = wa;
            exp.uop.reg1_read_addr = r1a;
            exp.uop.reg2_read_addr = r2a;
            exp.uop.aluop          = aluop;
            exp.uop.alusel         = alusel;
            exp.uop.imm            = imm;
            exp.uop.csr_addr       = csr;
            exp.uop.invtlb_op      = iop;
            exp.exc.is_exception   = exc_bits;
            exp.exc.pc_cause       = `EXCEPTION_ADEF;  // causes always filled
            exp.exc.fetch_cause    = `EXCEPTION_PIF;
            exp.exc.dec_cause      = `EXCEPTION_INE;
            vec_in.push_back(pkt);
            vec_exp.push_back(exp);
        end
        $fclose(fd);
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        fe_valid   = 1'b0;
        fe_pkt     = '0;
        dec_credit = 1'b0;
        seed       = 32'hb8e6_c1e0;
        load_vectors();
        nvec     = vec_in.size();
        loaded   = 1'b1;
        test_err = errors;

        repeat (5) begin
            @(negedge clk);
            check_flag("dec_valid in reset", dec_valid, 1'b0);
            check_flag("fe_credit in reset", fe_credit, 1'b0);
        end
        rst_n = 1'b1;
        @(negedge clk);
        check_flag("dec_valid after reset", dec_valid, 1'b0);
        check_flag("fe_credit after reset", fe_credit, 1'b0);
        report_test("reset");

        if (nvec == 0) begin
            errors++;
            $display("no vectors were read, nothing to run");
        end
        fe_cred = `IQ_DEPTH;
        while (nvec > 0 && (rcvd < nvec || be_due.size() != 0 || drain < 4)) begin
            if (rcvd == nvec && be_due.size() == 0) begin
                drain++;    // let last fe_credit pulses land
            end
            @(negedge clk);
            cycle++;
            if (fe_credit) begin
                fe_cred++;
                fe_pulses++;
            end
            if (dec_valid && rcvd >= nvec) begin
                errors++;
                $display("an output appeared after every vector had been received");
            end else if (dec_valid) begin
                if (rcvd == 0) begin
                    check_latency(cycle - sent_cycle, 2);
                    report_test("latency");
                end
                check_uop(rcvd, dec_out.uop, vec_exp[rcvd].uop);
                check_exc(rcvd, dec_out.exc, vec_exp[rcvd].exc);
                report_test($sformatf("vector %0d pc %h inst %h", rcvd,
                                      vec_in[rcvd].pc, vec_in[rcvd].inst));
                rcvd++;
                due = cycle + 1 + ($random(seed) & 7);
                if (due <= last_due) begin
                    due = last_due + 1;
                end
                last_due = due;
                be_due.push_back(due);
            end
            if (rcvd - be_returned > max_out) begin
                max_out = rcvd - be_returned;
            end
            dec_credit = 1'b0;
            if (be_due.size() != 0 && be_due[0] <= cycle) begin
                void'(be_due.pop_front());
                dec_credit = 1'b1;
                be_returned++;
            end
            fe_valid = 1'b0;
            // first packet goes alone into an empty pipeline
            if (sent < nvec && fe_cred > 0 && (sent == 0 || rcvd > 0) &&
                ($random(seed) & 3) != 0) begin
                fe_valid = 1'b1;
                fe_pkt   = vec_in[sent];
                fe_cred--;
                if (sent == 0) begin
                    sent_cycle = cycle;
                end
                sent++;
            end
        end
        fe_valid   = 1'b0;
        dec_credit = 1'b0;

        check_credit("peak back end credits in use", max_out, 0, `DQ_CREDITS);
        check_credit("fe_credit pulses", fe_pulses, nvec, nvec);
        report_test("credits");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        wait (loaded);
        repeat (nvec * 64 + 16) @(posedge clk);
        $display("timeout: the run did not drain within %0d cycles", nvec * 64 + 16);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/la_decode_vectors.txt ====
# pc inst fault flags{valid,we,r1,r2,priv,cnt,csr_re,csr_we} wr_addr r1_addr r2_addr
# aluop alusel imm csr_addr invtlb_op exc{decoder,fetch,pc}
1c000000 06483800 0 88 00 00 00 10 0 00000000 0040 00 0
1c000004 06482800 0 88 00 00 00 14 6 00000000 0040 00 0
1c000008 06482c00 0 88 00 00 00 15 6 00000000 0040 00 0
1c00000c 06483000 0 88 00 00 00 16 6 00000000 0040 00 0
1c000010 06483400 0 88 00 00 00 17 6 00000000 0040 00 0
1c000014 06499c65 0 b8 00 03 07 18 6 00000000 0040 05 0
1c000018 00006080 0 c6 04 00 00 11 6 00000000 0040 00 0
1c00001c 00006009 0 c4 09 00 00 12 6 00000000 0040 00 0
1c000020 0000640a 0 c4 0a 00 00 13 6 00000000 0040 00 0
1c000024 02bffc41 0 e0 01 02 00 01 1 ffffffff 0000 00 0
1c000028 02200083 0 e0 03 04 00 02 1 fffff800 0000 00 0
1c00002c 027c00c5 0 e0 05 06 00 03 1 ffffff00 0000 00 0
1c000030 037ffd07 0 e0 07 08 00 04 2 00000fff 0000 00 0
1c000034 03a003df 0 e0 1f 1e 00 05 2 00000800 0000 00 0
1c000038 03eaf230 0 e0 10 11 00 06 2 00000abc 0000 00 0
1c00003c ffffffff 0 00 00 00 00 00 0 00000000 0000 00 4
1c000040 00000000 0 00 00 00 00 00 0 00000000 0000 00 4
1c000046 02bffc41 0 e0 01 02 00 01 1 ffffffff 0000 00 1
1c000048 03a003df 1 e0 1f 1e 00 05 2 00000800 0000 00 2
1c00004d 06482c00 1 88 00 00 00 15 6 00000000 0040 00 3
1c00004f 12345678 1 00 00 00 00 00 0 00000000 0000 00 7
1c000052 0000640a 0 c4 0a 00 00 13 6 00000000 0040 00 1

// ==== la_decode.f ====
+incdir+hw
hw/la_decode_pkg.sv
hw/inst_queue.sv
hw/dec_priv_cnt.sv
hw/dec_alu_i12.sv
hw/decode_stage.sv
hw/la_decode_top.sv
tests/tb_la_decode.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_la_decode
FILELIST = la_decode.f
OBJ_DIR  = obj_dir

BIN  = $(OBJ_DIR)/V$(TOP)
SRCS = $(shell grep -v '^+' $(FILELIST)) $(wildcard hw/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf $(OBJ_DIR)
